//--- rxb.f
+incdir+include
hdl/rxb_stream_pkg.sv
hdl/rxb_frame_pkg.sv
hdl/rxb_if.sv
hdl/rxb_word_fifo.sv
hdl/rxb_lane_unpacker.sv
hdl/rxb_frame_sequencer.sv
hdl/rxb_top.sv
test/tb_rxb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rx frame rebuilder testbench with Verilator
# the run passes only if the log holds no failure line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_rxb -Mdir "$OBJ" -f rxb.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/Vtb_rxb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

//--- test/tb_rxb.sv
// --------------------------------------------------
// rx frame rebuilder testbench
// random packets into the word stream, framed bytes
// checked against a byte queue model, plus stall,
// packet count and reset checks
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_rxb;

	localparam int NUM_PKTS       = 40;
	localparam int MAX_WORDS      = 8;
	localparam int TIMEOUT_CYCLES = 13000;	// 40 * (8*8 + 13) bytes * 4 cycles, rounded up

	// frame characters, low bit order as sent
	localparam logic [7:0] START_CHAR = 8'hFB;
	localparam logic [7:0] PRE_CHAR   = 8'h55;
	localparam logic [7:0] SFD_CHAR   = 8'hD5;
	localparam logic [7:0] TERM_CHAR  = 8'hFD;
	localparam int         PRE_LEN    = 6;

	logic                     rx_mac_aclk = 1'b0;
	logic                     arst_n;
	rxb_stream_pkg::word_t    in_data;
	rxb_stream_pkg::keep_t    in_keep;
	logic                     in_last;
	logic                     in_valid;
	logic                     in_ready;
	rxb_stream_pkg::byte_t    out_data;
	logic                     out_ctrl;
	logic                     out_valid;
	logic                     out_ready = 1'b0;
	rxb_stream_pkg::pkt_cnt_t pkt_cnt;

	integer seed = 17;

	// input words in send order
	rxb_stream_pkg::word_t word_q [$];
	rxb_stream_pkg::keep_t keep_q [$];
	logic                  last_q [$];
	int unsigned           gap_q  [$];	// idle cycles ahead of the word
	logic [8:0]            exp_q  [$];	// {ctrl, byte}, oldest first

	int         term_seen    = 0;		// 0xFD bytes gone out so far
	int         cycle_cnt    = 0;
	logic       hold_pending = 1'b0;	// byte stalled on the last edge
	logic [7:0] held_data;
	logic       held_ctrl;
	logic [8:0] exp_entry;

	always #50 rx_mac_aclk = ~rx_mac_aclk;

	rxb_top i_dut (
		.rx_mac_aclk (rx_mac_aclk),
		.arst_n      (arst_n),
		.in_data     (in_data),
		.in_keep     (in_keep),
		.in_last     (in_last),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.out_data    (out_data),
		.out_ctrl    (out_ctrl),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.pkt_cnt     (pkt_cnt)
	);

	// uniform pick in 0..n-1
	function automatic int unsigned rand_range(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	// low n lanes kept
	function automatic rxb_stream_pkg::keep_t keep_for_count(input int n);
		rxb_stream_pkg::keep_t k;
		k = '0;
		for (int i = 0; i < n; i++)
			k[i] = 1'b1;
		return k;
	endfunction

	// words for every packet, and the framed bytes they should turn into
	function automatic void build_packets();
		int                    nwords;
		int                    nlast;
		int                    nbytes;
		rxb_stream_pkg::word_t data;
		for (int p = 0; p < NUM_PKTS; p++) begin
			nwords = 1 + int'(rand_range(MAX_WORDS));
			nlast  = 1 + int'(rand_range(8));	// kept lanes of the last word
			exp_q.push_back({1'b1, START_CHAR});
			for (int i = 0; i < PRE_LEN; i++)
				exp_q.push_back({1'b0, PRE_CHAR});
			exp_q.push_back({1'b0, SFD_CHAR});
			for (int w = 0; w < nwords; w++) begin
				data   = {$random(seed), $random(seed)};	// dropped lanes carry junk too
				nbytes = (w == nwords - 1) ? nlast : 8;
				for (int b = 0; b < nbytes; b++)
					exp_q.push_back({1'b0, data[b*8 +: 8]});	// low lane first
				word_q.push_back(data);
				keep_q.push_back(keep_for_count(nbytes));
				last_q.push_back(w == nwords - 1);
				gap_q.push_back(rand_range(3));
			end
			for (int t = 0; t < 4; t++)
				exp_q.push_back({1'b0, 8'hC1 + 8'(t)});	// C1..C4
			exp_q.push_back({1'b1, TERM_CHAR});
		end
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		abort_run($sformatf("** Error at %0d ns: %s = 0x%0h, expected 0x%0h",
			$time, name, got, want));
	endtask

	task automatic check_idle_outputs();
		assert (out_valid == 1'b0)
			else report_mismatch("out_valid", 32'(out_valid), 32'd0);
		assert (pkt_cnt == '0)
			else report_mismatch("pkt_cnt", pkt_cnt, 32'd0);
		assert (in_ready == 1'b1)
			else report_mismatch("in_ready", 32'(in_ready), 32'd1);
	endtask

	// called on a rising edge, returns on the edge that took the word
	task automatic send_word(input rxb_stream_pkg::word_t data,
			input rxb_stream_pkg::keep_t keep, input logic last, input int unsigned gap);
		logic accepted;
		if (gap > 0) begin
			in_valid <= 1'b0;
			repeat (gap) @(posedge rx_mac_aclk);
		end
		in_data  <= data;
		in_keep  <= keep;
		in_last  <= last;
		in_valid <= 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge rx_mac_aclk);
			accepted = in_ready;	// transfer on the coming edge
			@(posedge rx_mac_aclk);
		end
	endtask

	// sink takes a byte on roughly 70% of cycles
	always @(posedge rx_mac_aclk)
		out_ready <= (rand_range(10) < 7);

	always @(posedge rx_mac_aclk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run($sformatf("timeout, frames still missing after %0d cycles", cycle_cnt));
	end

	// output side sampled mid-cycle, where everything is settled
	always @(negedge rx_mac_aclk) begin
		if (!arst_n) begin
			hold_pending = 1'b0;
		end else begin
			if (hold_pending) begin
				assert (out_valid)
					else abort_run($sformatf("out_valid dropped at %0d ns during a stall", $time));
				assert (out_data == held_data)
					else report_mismatch("out_data", 32'(out_data), 32'(held_data));
				assert (out_ctrl == held_ctrl)
					else report_mismatch("out_ctrl", 32'(out_ctrl), 32'(held_ctrl));
			end
			assert (pkt_cnt == 32'(term_seen))
				else report_mismatch("pkt_cnt", pkt_cnt, 32'(term_seen));
			if (out_valid && out_ready) begin
				assert (exp_q.size() > 0)
					else abort_run("a byte went out after the last expected byte");
				exp_entry = exp_q.pop_front();
				assert (out_data == exp_entry[7:0])
					else report_mismatch("out_data", 32'(out_data), 32'(exp_entry[7:0]));
				assert (out_ctrl == exp_entry[8])
					else report_mismatch("out_ctrl", 32'(out_ctrl), 32'(exp_entry[8]));
				if (exp_entry == {1'b1, TERM_CHAR})
					term_seen++;	// counter should follow one edge later
			end
			hold_pending = out_valid && !out_ready;
			held_data    = out_data;
			held_ctrl    = out_ctrl;
		end
	end

	initial begin : stimulus
		arst_n   <= 1'b0;
		in_data  <= '0;
		in_keep  <= '0;
		in_last  <= 1'b0;
		in_valid <= 1'b0;
		build_packets();
		repeat (8) begin
			@(negedge rx_mac_aclk);
			check_idle_outputs();	// quiet under reset
		end
		@(posedge rx_mac_aclk);
		arst_n <= 1'b1;
		@(negedge rx_mac_aclk);
		check_idle_outputs();		// still quiet right after release
		@(posedge rx_mac_aclk);
		while (word_q.size() > 0)
			send_word(word_q.pop_front(), keep_q.pop_front(), last_q.pop_front(),
				gap_q.pop_front());
		in_valid <= 1'b0;
		while (term_seen < NUM_PKTS)
			@(posedge rx_mac_aclk);
		repeat (4) @(posedge rx_mac_aclk);	// room for any stray byte to show
		assert (exp_q.size() == 0)
			else abort_run($sformatf("%0d expected bytes never came out", exp_q.size()));
		assert (pkt_cnt == 32'(NUM_PKTS))
			else report_mismatch("pkt_cnt", pkt_cnt, 32'(NUM_PKTS));
		assert (!out_valid)
			else abort_run("a byte is still offered after the last frame");
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/rxb_top.sv
// ------------------------------------------------
// rx frame rebuilder top
// word FIFO, lane unpacker and frame sequencer
// joined by the word and byte streams
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rxb_top (
	input  logic                     rx_mac_aclk,
	input  logic                     arst_n,
	// packet words in
	input  rxb_stream_pkg::word_t    in_data,
	input  rxb_stream_pkg::keep_t    in_keep,
	input  logic                     in_last,
	input  logic                     in_valid,
	output logic                     in_ready,
	// framed bytes out
	output rxb_stream_pkg::byte_t    out_data,
	output logic                     out_ctrl,	// high on 0xFB and 0xFD
	output logic                     out_valid,
	input  logic                     out_ready,
	output rxb_stream_pkg::pkt_cnt_t pkt_cnt
);

	rxb_word_if word ();	// FIFO head to unpacker
	rxb_byte_if pay ();	// payload bytes to sequencer

	rxb_word_fifo i_word_fifo (
		.rx_mac_aclk (rx_mac_aclk),
		.arst_n      (arst_n),
		.in_data     (in_data),
		.in_keep     (in_keep),
		.in_last     (in_last),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.word        (word.src)
	);

	rxb_lane_unpacker i_lane_unpacker (
		.rx_mac_aclk (rx_mac_aclk),
		.arst_n      (arst_n),
		.word        (word.dst),
		.pay         (pay.src)
	);

	rxb_frame_sequencer i_frame_sequencer (
		.rx_mac_aclk (rx_mac_aclk),
		.arst_n      (arst_n),
		.pay         (pay.dst),
		.out_data    (out_data),
		.out_ctrl    (out_ctrl),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.pkt_cnt     (pkt_cnt)
	);

endmodule

`default_nettype wire

//--- hdl/rxb_frame_sequencer.sv
// ------------------------------------------------
// rx frame sequencer
// wraps payload bytes in start, preamble, SFD,
// trailer and terminate bytes, counts frames
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rxb_macros.svh"

module rxb_frame_sequencer (
	input  logic                     rx_mac_aclk,
	input  logic                     arst_n,
	rxb_byte_if.dst                  pay,
	output rxb_stream_pkg::byte_t    out_data,
	output logic                     out_ctrl,
	output logic                     out_valid,
	input  logic                     out_ready,
	output rxb_stream_pkg::pkt_cnt_t pkt_cnt
);

	localparam int CW = $clog2(`RXB_PREAMBLE_LEN);	// shared section counter

	rxb_frame_pkg::seq_state_t state;
	logic [CW-1:0]             cnt;		// preamble or trailer position
	logic                      out_xfer;

	assign out_xfer = out_valid && out_ready;

	// payload accepted only while passing it through
	assign pay.ready = (state == rxb_frame_pkg::S_PAYLOAD) && out_ready;

	// control flag on the two framing characters only
	assign out_ctrl = (state == rxb_frame_pkg::S_START) || (state == rxb_frame_pkg::S_TERM);

	always_comb begin
		out_valid = 1'b1;
		case (state)
			rxb_frame_pkg::S_START:    out_data = rxb_frame_pkg::CH_START;
			rxb_frame_pkg::S_PREAMBLE: out_data = rxb_frame_pkg::CH_PREAMBLE;
			rxb_frame_pkg::S_SFD:      out_data = rxb_frame_pkg::CH_SFD;
			rxb_frame_pkg::S_PAYLOAD: begin
				out_data  = pay.data;
				out_valid = pay.valid;	// bubbles when the unpacker has nothing
			end
			rxb_frame_pkg::S_TRAILER:  out_data = rxb_frame_pkg::TRAILER[cnt[1:0]];
			rxb_frame_pkg::S_TERM:     out_data = rxb_frame_pkg::CH_TERM;
			default: begin
				out_data  = '0;			// idle, nothing on the line
				out_valid = 1'b0;
			end
		endcase
	end

	always_ff @(posedge rx_mac_aclk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= rxb_frame_pkg::S_IDLE;
			cnt     <= '0;
			pkt_cnt <= '0;
		end else begin
			case (state)
				rxb_frame_pkg::S_IDLE: begin
					if (pay.valid)
						state <= rxb_frame_pkg::S_START;	// packet waiting
				end
				rxb_frame_pkg::S_START: begin
					if (out_xfer) begin
						state <= rxb_frame_pkg::S_PREAMBLE;
						cnt   <= '0;
					end
				end
				rxb_frame_pkg::S_PREAMBLE: begin
					if (out_xfer) begin
						if (cnt == CW'(`RXB_PREAMBLE_LEN - 1))
							state <= rxb_frame_pkg::S_SFD;
						cnt <= cnt + 1'b1;
					end
				end
				rxb_frame_pkg::S_SFD: begin
					if (out_xfer)
						state <= rxb_frame_pkg::S_PAYLOAD;
				end
				rxb_frame_pkg::S_PAYLOAD: begin
					if (out_xfer && pay.last) begin
						state <= rxb_frame_pkg::S_TRAILER;
						cnt   <= '0;		// counter reused for C1..C4
					end
				end
				rxb_frame_pkg::S_TRAILER: begin
					if (out_xfer) begin
						if (cnt == CW'(3))
							state <= rxb_frame_pkg::S_TERM;
						cnt <= cnt + 1'b1;
					end
				end
				rxb_frame_pkg::S_TERM: begin
					if (out_xfer) begin
						state   <= rxb_frame_pkg::S_IDLE;
						pkt_cnt <= pkt_cnt + 1'b1;	// frame done once 0xFD goes
					end
				end
				default: state <= rxb_frame_pkg::S_IDLE;
			endcase
		end
	end

	// flagged bytes are always start or terminate characters
	a_ctrl_chars: assert property (@(posedge rx_mac_aclk) disable iff (!arst_n)
		out_valid && out_ctrl |->
		(out_data == rxb_frame_pkg::CH_START) || (out_data == rxb_frame_pkg::CH_TERM));

	// a held byte keeps its value and flag until it goes
	a_out_hold: assert property (@(posedge rx_mac_aclk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_ctrl));

endmodule

`default_nettype wire

//--- hdl/rxb_lane_unpacker.sv
// ------------------------------------------------
// rx lane unpacker
// walks the byte lanes of the head word, low lane
// first, stopping at the last kept lane
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rxb_macros.svh"

module rxb_lane_unpacker (
	input  logic    rx_mac_aclk,
	input  logic    arst_n,
	rxb_word_if.dst word,
	rxb_byte_if.src pay
);

	localparam int LW = $clog2(`RXB_DATA_BYTES);	// lane index width

	logic [LW-1:0] lane;		// lane currently offered
	logic [LW-1:0] last_lane;	// highest kept lane of the head word
	logic          lane_end;
	logic          xfer;

	// highest set keep bit, lane 7 on full words
	always_comb begin
		last_lane = '0;
		for (int i = 0; i < `RXB_DATA_BYTES; i++) begin
			if (word.keep[i])
				last_lane = LW'(i);
		end
	end

	assign lane_end = (lane == last_lane);
	assign xfer     = pay.valid && pay.ready;

	// one byte per cycle straight from the head word
	assign pay.valid = word.valid;
	assign pay.data  = word.data[lane*8 +: 8];
	assign pay.last  = word.last && lane_end;	// end of packet only on a last word

	// pop once the final kept byte goes
	assign word.ready = xfer && lane_end;

	always_ff @(posedge rx_mac_aclk or negedge arst_n) begin
		if (!arst_n) begin
			lane <= '0;
		end else if (xfer) begin
			if (lane_end)
				lane <= '0;			// next word starts at lane 0
			else
				lane <= lane + 1'b1;
		end
	end

	// mid-packet words from the FIFO carry every lane
	a_full_keep: assert property (@(posedge rx_mac_aclk) disable iff (!arst_n)
		word.valid && !word.last |-> word.keep == '1);

endmodule

`default_nettype wire

//--- hdl/rxb_word_fifo.sv
// ------------------------------------------------
// rx word FIFO
// buffers incoming words with keep mask and last
// flag, circular buffer with wrap-bit pointers
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rxb_macros.svh"

module rxb_word_fifo (
	input  logic                  rx_mac_aclk,
	input  logic                  arst_n,
	input  rxb_stream_pkg::word_t in_data,
	input  rxb_stream_pkg::keep_t in_keep,
	input  logic                  in_last,
	input  logic                  in_valid,
	output logic                  in_ready,
	rxb_word_if.src               word
);

	localparam int AW = $clog2(`RXB_FIFO_DEPTH);	// address bits, one more for wrap

	// storage, one entry per word
	rxb_stream_pkg::word_t mem_data [`RXB_FIFO_DEPTH];
	rxb_stream_pkg::keep_t mem_keep [`RXB_FIFO_DEPTH];
	logic                  mem_last [`RXB_FIFO_DEPTH];

	logic [AW:0] wr_ptr;	// msb is the wrap bit
	logic [AW:0] rd_ptr;
	logic [AW:0] fill;	// words held
	logic        full;
	logic        empty;
	logic        wr_en;
	logic        rd_en;

	// same address, different lap means full
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign empty = (wr_ptr == rd_ptr);
	assign fill  = wr_ptr - rd_ptr;

	assign in_ready = !full;
	assign wr_en    = in_valid && in_ready;
	assign rd_en    = word.valid && word.ready;	// head word consumed

	// head of buffer straight onto the word stream
	assign word.valid = !empty;
	assign word.data  = mem_data[rd_ptr[AW-1:0]];
	assign word.keep  = mem_keep[rd_ptr[AW-1:0]];
	assign word.last  = mem_last[rd_ptr[AW-1:0]];

	always_ff @(posedge rx_mac_aclk) begin
		if (wr_en) begin
			mem_data[wr_ptr[AW-1:0]] <= in_data;
			mem_keep[wr_ptr[AW-1:0]] <= in_keep;
			mem_last[wr_ptr[AW-1:0]] <= in_last;
		end
	end

	always_ff @(posedge rx_mac_aclk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// a write landing on a full buffer would push the fill past the depth
	a_no_wr_when_full: assert property (@(posedge rx_mac_aclk) disable iff (!arst_n)
		fill <= `RXB_FIFO_DEPTH);

	// last word keeps a nonzero run of lanes from lane 0
	a_last_keep: assert property (@(posedge rx_mac_aclk) disable iff (!arst_n)
		in_valid && in_last |-> (in_keep != '0) &&
		((in_keep & (in_keep + 1'b1)) == '0));

endmodule

`default_nettype wire

//--- hdl/rxb_if.sv
// ------------------------------------------------
// rx frame rebuilder internal streams
// word stream from the FIFO to the unpacker and
// byte stream from the unpacker to the sequencer
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

// buffered words, keep and last travel with the data
interface rxb_word_if;
	rxb_stream_pkg::word_t data;
	rxb_stream_pkg::keep_t keep;
	logic                  last;	// final word of a packet
	logic                  valid;
	logic                  ready;

	modport src (
		output data, keep, last, valid,
		input  ready
	);

	modport dst (
		input  data, keep, last, valid,
		output ready
	);
endinterface

// payload bytes, last marks the final byte of a packet
interface rxb_byte_if;
	rxb_stream_pkg::byte_t data;
	logic                  last;
	logic                  valid;
	logic                  ready;

	modport src (
		output data, last, valid,
		input  ready
	);

	modport dst (
		input  data, last, valid,
		output ready
	);
endinterface

`default_nettype wire

//--- hdl/rxb_frame_pkg.sv
// ------------------------------------------------
// rx frame rebuilder frame encoding
// start, preamble, delimiter, trailer and terminate
// characters plus the sequencer state type
// ------------------------------------------------

`default_nettype none

package rxb_frame_pkg;

	// control characters, flagged on out_ctrl
	localparam rxb_stream_pkg::byte_t CH_START = 8'hFB;
	localparam rxb_stream_pkg::byte_t CH_TERM  = 8'hFD;

	// plain frame bytes around the payload
	localparam rxb_stream_pkg::byte_t CH_PREAMBLE = 8'h55;
	localparam rxb_stream_pkg::byte_t CH_SFD      = 8'hD5;

	// fixed trailer in place of the FCS, entry 0 goes out first
	localparam logic [3:0][7:0] TRAILER = {8'hC4, 8'hC3, 8'hC2, 8'hC1};

	// one state per frame section
	typedef enum logic [2:0] {
		S_IDLE     = 3'd0,	// waiting for a payload byte
		S_START    = 3'd1,	// 0xFB out
		S_PREAMBLE = 3'd2,	// 0x55 bytes out
		S_SFD      = 3'd3,	// 0xD5 out
		S_PAYLOAD  = 3'd4,	// packet bytes pass through
		S_TRAILER  = 3'd5,	// C1..C4 out
		S_TERM     = 3'd6	// 0xFD out, frame counted
	} seq_state_t;

endpackage

`default_nettype wire

//--- hdl/rxb_stream_pkg.sv
// ------------------------------------------------
// rx frame rebuilder stream types
// payload word, keep mask, output byte and the
// packet count carried on the streams
// ------------------------------------------------

`default_nettype none

`include "rxb_macros.svh"

package rxb_stream_pkg;

	// one input word, lane 0 in the low byte
	typedef logic [`RXB_DATA_BYTES*8-1:0] word_t;

	// one bit per byte lane, bit 0 is lane 0
	typedef logic [`RXB_DATA_BYTES-1:0] keep_t;

	// single byte on the rebuilt frame stream
	typedef logic [7:0] byte_t;

	// running count of frames sent
	typedef logic [31:0] pkt_cnt_t;

endpackage

`default_nettype wire

//--- include/rxb_macros.svh
// ------------------------------------------------
// rx frame rebuilder constants
// word width, word FIFO depth and preamble length
// shared by the packages and the RTL blocks
// ------------------------------------------------

`ifndef RXB_MACROS_SVH
`define RXB_MACROS_SVH

// bytes in one input word, 64-bit MAC data path
`define RXB_DATA_BYTES 8

// word entries in the input FIFO, keep a power of two
`define RXB_FIFO_DEPTH 16

// number of 0x55 bytes ahead of the delimiter
`define RXB_PREAMBLE_LEN 6

`endif
